/* hdl/control_panel.sv */
//============================================================
// Control panel top level
// Game configuration, PS/2 decoding and the switch matrix
// read by the CPU column strobe
//============================================================

`timescale 1ns/1ns
`default_nettype none

module control_panel #(
	parameter int DIP_BANK_FIRST = 2  // Loader address of DIP bank pair
) (
	input  wire                     clk_sys,
	input  wire                     reset,

	// Loader bus
	input  wire                     load_wr,
	input  panel_pkg::load_index_t  load_index,
	input  panel_pkg::load_addr_t   load_addr,
	input  panel_pkg::byte_t        load_data,

	// Player inputs
	input  panel_pkg::ps2_key_t     ps2_key,
	input  panel_pkg::joy_t         joy_p1,
	input  panel_pkg::joy_t         joy_p2,
	input  wire                     speech_busy,

	// CPU side
	input  panel_pkg::col_sel_t     col_select,
	output panel_pkg::byte_t        row_data
);

	import panel_pkg::*;

	game_flags_t game_flags;
	byte_t       dip_a;      // Bank 2 by default
	byte_t       dip_b;      // Bank 3 by default
	player_btn_t key_p1;
	player_btn_t key_p2;
	system_btn_t key_sys;

	//============================================================
	// Game configuration
	//============================================================
	game_config #(
		.DIP_BANK_FIRST (DIP_BANK_FIRST)
	) config0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.game_flags (game_flags),
		.dip_a      (dip_a),
		.dip_b      (dip_b)
	);

	// Keyboard
	key_decoder keys0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.key_p1  (key_p1),
		.key_p2  (key_p2),
		.key_sys (key_sys)
	);

	// Input matrix, combinational
	switch_matrix matrix0 (
		.game_flags  (game_flags),
		.dip_a       (dip_a),
		.dip_b       (dip_b),
		.key_p1      (key_p1),
		.key_p2      (key_p2),
		.key_sys     (key_sys),
		.joy_p1      (joy_p1),
		.joy_p2      (joy_p2),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

endmodule

`default_nettype wire

/* hdl/game_config.sv */
//============================================================
// Game configuration
// Captures game number and two DIP banks from loader writes,
// registers the one-hot game flags
//============================================================

`timescale 1ns/1ns
`default_nettype none

module game_config #(
	parameter int DIP_BANK_FIRST = 2  // Loader address of first kept bank
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     load_wr,     // Single-cycle strobe
	input  panel_pkg::load_index_t  load_index,
	input  panel_pkg::load_addr_t   load_addr,
	input  panel_pkg::byte_t        load_data,
	output panel_pkg::game_flags_t  game_flags,
	output panel_pkg::byte_t        dip_a,       // First kept bank
	output panel_pkg::byte_t        dip_b        // Second kept bank
);

	import panel_pkg::*;

	// Addresses of the kept DIP pair
	localparam load_addr_t DIP_ADDR_A = load_addr_t'(DIP_BANK_FIRST);
	localparam load_addr_t DIP_ADDR_B = load_addr_t'(DIP_BANK_FIRST + 1);

	byte_t game_num;     // Last game number written
	logic  game_wr;
	logic  dip_wr;

	assign game_wr = load_wr && (load_index == INDEX_GAME);
	assign dip_wr  = load_wr && (load_index == INDEX_DIP);

	//============================================================
	// Game number and flag decode
	//============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_num <= '0;
		end else if (game_wr) begin
			game_num <= load_data;
		end
	end

	// Decode one cycle behind the number itself
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_flags <= '0;
		end else begin
			game_flags.spacezap <= (game_num == GAME_SPACEZAP);
			game_flags.gorf     <= (game_num == GAME_GORF);
			game_flags.robby    <= (game_num == GAME_ROBBY);
		end
	end

	//============================================================
	// DIP banks
	//============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dip_a <= '0;
			dip_b <= '0;
		end else if (dip_wr) begin
			if (load_addr == DIP_ADDR_A)
				dip_a <= load_data;
			if (load_addr == DIP_ADDR_B)
				dip_b <= load_data;
			// Any other bank address dropped
		end
	end

endmodule

`default_nettype wire

/* hdl/key_decoder.sv */
//============================================================
// PS/2 key decoder
// Turns key events into latched button states for
// both players and the system buttons
//============================================================

`timescale 1ns/1ns
`default_nettype none

module key_decoder (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  panel_pkg::ps2_key_t     ps2_key,
	output panel_pkg::player_btn_t  key_p1,
	output panel_pkg::player_btn_t  key_p2,
	output panel_pkg::system_btn_t  key_sys
);

	import panel_pkg::*;

	// Player 1 arrows, extended bit ignored
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_CTRL  = 8'h14;  // P1 fire

	// Player 2 letter keys
	localparam logic [7:0] SC_R = 8'h2D;
	localparam logic [7:0] SC_F = 8'h2B;
	localparam logic [7:0] SC_D = 8'h23;
	localparam logic [7:0] SC_G = 8'h34;
	localparam logic [7:0] SC_A = 8'h1C;

	// Start and coin, function key or number key
	localparam logic [7:0] SC_F1 = 8'h05;
	localparam logic [7:0] SC_F2 = 8'h06;
	localparam logic [7:0] SC_F3 = 8'h04;
	localparam logic [7:0] SC_1  = 8'h16;
	localparam logic [7:0] SC_2  = 8'h1E;
	localparam logic [7:0] SC_5  = 8'h2E;

	logic       toggle_q;   // Toggle seen last cycle
	logic       key_event;
	logic       extended;
	logic [7:0] scan;

	// One register per system key
	logic start1_fkey, start1_num;
	logic start2_fkey, start2_num;
	logic coin_fkey, coin_num;

	assign key_event = (ps2_key.toggle != toggle_q);
	assign extended  = ps2_key.code[8];
	assign scan      = ps2_key.code[7:0];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q    <= 1'b0;
			key_p1      <= '0;
			key_p2      <= '0;
			start1_fkey <= 1'b0;
			start1_num  <= 1'b0;
			start2_fkey <= 1'b0;
			start2_num  <= 1'b0;
			coin_fkey   <= 1'b0;
			coin_num    <= 1'b0;
		end else begin
			toggle_q <= ps2_key.toggle;
			if (key_event) begin
				case (scan)
					SC_UP:    key_p1.up    <= ps2_key.pressed;
					SC_DOWN:  key_p1.down  <= ps2_key.pressed;
					SC_LEFT:  key_p1.left  <= ps2_key.pressed;
					SC_RIGHT: key_p1.right <= ps2_key.pressed;
					default: ;
				endcase
				// Everything else only as a plain code
				if (!extended) begin
					case (scan)
						SC_CTRL: key_p1.fire  <= ps2_key.pressed;
						SC_R:    key_p2.up    <= ps2_key.pressed;
						SC_F:    key_p2.down  <= ps2_key.pressed;
						SC_D:    key_p2.left  <= ps2_key.pressed;
						SC_G:    key_p2.right <= ps2_key.pressed;
						SC_A:    key_p2.fire  <= ps2_key.pressed;
						SC_F1:   start1_fkey  <= ps2_key.pressed;
						SC_1:    start1_num   <= ps2_key.pressed;
						SC_F2:   start2_fkey  <= ps2_key.pressed;
						SC_2:    start2_num   <= ps2_key.pressed;
						SC_F3:   coin_fkey    <= ps2_key.pressed;
						SC_5:    coin_num     <= ps2_key.pressed;
						default: ;  // Unmapped, no change
					endcase
				end
			end
		end
	end

	// Either key of a pair counts
	assign key_sys.start1 = start1_fkey | start1_num;
	assign key_sys.start2 = start2_fkey | start2_num;
	assign key_sys.coin   = coin_fkey | coin_num;

endmodule

`default_nettype wire

/* hdl/panel_pkg.sv */
//============================================================
// Control panel package
// Loader and panel widths, button structs, game numbers
//============================================================

`default_nettype none

package panel_pkg;

	//============================================================
	// Bus widths
	//============================================================
	typedef logic [24:0] load_addr_t;   // Loader byte address
	typedef logic [7:0]  load_index_t;  // Loader target index
	typedef logic [7:0]  byte_t;        // Data byte, DIP bank, row byte
	typedef logic [7:0]  col_sel_t;     // One-hot column strobe
	typedef logic [15:0] joy_t;         // Host joystick word

	// Joystick word bit positions
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE   = 4;
	localparam int JOY_START1 = 6;
	localparam int JOY_START2 = 7;
	localparam int JOY_COIN   = 8;

	//============================================================
	// Button groups
	//============================================================
	typedef struct packed {
		logic       toggle;   // Flips once per key event
		logic       pressed;  // Make or break
		logic [8:0] code;     // Bit 8 marks E0 extended codes
	} ps2_key_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} player_btn_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} system_btn_t;

	// One-hot, all zero when no known game loaded
	typedef struct packed {
		logic spacezap;
		logic gorf;
		logic robby;
	} game_flags_t;

	//============================================================
	// Loader and game constants
	//============================================================
	localparam load_index_t INDEX_GAME = 8'd1;    // Game number write
	localparam load_index_t INDEX_DIP  = 8'd254;  // DIP bank write

	localparam byte_t GAME_SPACEZAP = 8'd3;
	localparam byte_t GAME_GORF     = 8'd4;
	localparam byte_t GAME_ROBBY    = 8'd6;

	localparam byte_t ROW_IDLE = 8'hFF;  // Nothing pressed, switches open

endpackage

`default_nettype wire

/* hdl/switch_matrix.sv */
//============================================================
// Switch matrix
// Merges keyboard and joystick, answers the CPU column
// strobe with the row byte of the selected game
//============================================================

`timescale 1ns/1ns
`default_nettype none

module switch_matrix (
	input  panel_pkg::game_flags_t  game_flags,
	input  panel_pkg::byte_t        dip_a,
	input  panel_pkg::byte_t        dip_b,
	input  panel_pkg::player_btn_t  key_p1,
	input  panel_pkg::player_btn_t  key_p2,
	input  panel_pkg::system_btn_t  key_sys,
	input  panel_pkg::joy_t         joy_p1,
	input  panel_pkg::joy_t         joy_p2,
	input  wire                     speech_busy,  // Gorf speech chip busy
	input  panel_pkg::col_sel_t     col_select,
	output panel_pkg::byte_t        row_data
);

	import panel_pkg::*;

	localparam col_sel_t COL_1 = 8'h01;
	localparam col_sel_t COL_2 = 8'h02;
	localparam col_sel_t COL_4 = 8'h04;
	localparam col_sel_t COL_8 = 8'h08;

	player_btn_t p1;
	player_btn_t p2;
	system_btn_t sys;

	byte_t sz_col1, sz_col2, sz_col4;
	byte_t gf_col1, gf_col2, gf_col4;
	byte_t rr_col1, rr_col2, rr_col4;

	// Active-low direction nibble, right left down up
	function automatic logic [3:0] dir_low(input player_btn_t b);
		return {~b.right, ~b.left, ~b.down, ~b.up};
	endfunction

	// Merged player buttons in one function
	function automatic player_btn_t merge_player(input player_btn_t k, input joy_t j);
		player_btn_t m;
		m.up    = k.up    | j[JOY_UP];
		m.down  = k.down  | j[JOY_DOWN];
		m.left  = k.left  | j[JOY_LEFT];
		m.right = k.right | j[JOY_RIGHT];
		m.fire  = k.fire  | j[JOY_FIRE];
		return m;
	endfunction

	//============================================================
	// Keyboard OR joystick
	//============================================================
	assign p1 = merge_player(key_p1, joy_p1);
	assign p2 = merge_player(key_p2, joy_p2);

	// System buttons only on the first joystick
	assign sys.start1 = key_sys.start1 | joy_p1[JOY_START1];
	assign sys.start2 = key_sys.start2 | joy_p1[JOY_START2];
	assign sys.coin   = key_sys.coin   | joy_p1[JOY_COIN];

	//============================================================
	// Per-game rows, bit 7 first
	//============================================================
	// Space Zap
	assign sz_col1 = {2'b11, ~sys.start2, ~sys.start1, dip_a[1], 1'b1, ~sys.coin, 1'b1};
	assign sz_col2 = {3'b111, ~p2.fire, dir_low(p2)};
	assign sz_col4 = {2'b11, dip_a[0], ~p1.fire, dir_low(p1)};

	// Gorf, speech busy on top of P1 column
	assign gf_col1 = {dip_a[2], dip_a[0], ~sys.start2, ~sys.start1, 1'b1, dip_a[1],
		~sys.coin, 1'b1};
	assign gf_col2 = {3'b001, ~p2.fire, dir_low(p2)};
	assign gf_col4 = {speech_busy, 2'b01, ~p1.fire, dir_low(p1)};

	// Robby Roto, fire sits above a fixed one
	assign rr_col1 = {1'b0, ~sys.start2, ~sys.start1, 1'b1, dip_a[1], 1'b1, ~sys.coin, 1'b1};
	assign rr_col2 = {2'b11, ~p2.fire, 1'b1, dir_low(p2)};
	assign rr_col4 = {2'b11, ~p1.fire, 1'b1, dir_low(p1)};

	//============================================================
	// Column select
	//============================================================
	always_comb begin
		row_data = ROW_IDLE;  // Unknown column or no game
		case (col_select)
			COL_1: begin
				if (game_flags.spacezap)   row_data = sz_col1;
				else if (game_flags.gorf)  row_data = gf_col1;
				else if (game_flags.robby) row_data = rr_col1;
			end
			COL_2: begin
				if (game_flags.spacezap)   row_data = sz_col2;
				else if (game_flags.gorf)  row_data = gf_col2;
				else if (game_flags.robby) row_data = rr_col2;
			end
			COL_4: begin
				if (game_flags.spacezap)   row_data = sz_col4;
				else if (game_flags.gorf)  row_data = gf_col4;
				else if (game_flags.robby) row_data = rr_col4;
			end
			COL_8:   row_data = dip_b;  // Same for every game
			default: row_data = ROW_IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the control panel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_control_panel \
	-Mdir obj_dir -o sim_control_panel

./obj_dir/sim_control_panel > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
exit 0

/* sim/panel_checker.sv */
//============================================================
// Panel checker
// Compares row_data with the reference byte on each edge
// where a check is armed, counts checks and errors
//============================================================

`timescale 1ns/1ns
`default_nettype none

module panel_checker (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  check_en,    // Expected byte valid this cycle
	input  panel_pkg::col_sel_t  col_select,
	input  panel_pkg::byte_t     row_data,
	input  panel_pkg::byte_t     expected,
	output int                   checks,
	output int                   errors
);

	import panel_pkg::*;

	col_sel_t col_seen;  // Column of the current sample

	assign col_seen = col_select;

	//============================================================
	// Compare, values held stable since the last edge
	//============================================================
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			checks <= 0;
			errors <= 0;
		end else if (check_en) begin
			checks <= checks + 1;
			if (row_data !== expected) begin
				errors <= errors + 1;
				$display("error row_data col_select=%h got %h expected %h at %0t ns",
					col_seen, row_data, expected, $time);
			end
		end else if ($isunknown(row_data)) begin
			// Between checks the row must still be driven
			errors <= errors + 1;
			$display("error row_data col_select=%h got %h, unknown bits at %0t ns",
				col_seen, row_data, $time);
		end
	end

endmodule

`default_nettype wire

/* sim/tb_control_panel.sv */
//============================================================
// Control panel testbench
// Random loader, keyboard and joystick stimulus checked
// against a reference model of the row byte
//============================================================

`timescale 1ns/1ns
`default_nettype none

module tb_control_panel;

	import panel_pkg::*;

	localparam int DIP_FIRST   = 2;
	localparam int CHECK_LIMIT = 100;  // Cycles allowed for the checker to drain

	// Key table, position in table is the model slot
	localparam byte_t KEY_CODES [0:15] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h14,
		8'h2D, 8'h2B, 8'h23, 8'h34, 8'h1C, 8'h05, 8'h16, 8'h06, 8'h1E, 8'h04, 8'h2E};

	logic        clk_sys;
	logic        reset;
	logic        load_wr;
	load_index_t load_index;
	load_addr_t  load_addr;
	byte_t       load_data;
	ps2_key_t    ps2_key;
	joy_t        joy_p1;
	joy_t        joy_p2;
	logic        speech_busy;
	col_sel_t    col_select;
	byte_t       row_data;

	byte_t expected;   // Reference byte for the checker
	logic  check_en;
	int    checks;
	int    errors;
	int    issued;     // Checks handed to the checker
	logic  timed_out;

	// Reference model
	byte_t       m_game;
	byte_t       m_dip_a;
	byte_t       m_dip_b;
	logic [15:0] keys;      // Latched keys, KEY_CODES order
	joy_t        m_joy1;
	joy_t        m_joy2;
	logic        m_speech;
	logic        m_toggle;

	control_panel #(.DIP_BANK_FIRST(DIP_FIRST)) dut0 (.*);

	panel_checker check0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;  // 8 ns period
	end

	// Slot of a key event, -1 when unmapped
	function automatic int key_slot(input logic [8:0] code);
		int i;
		int slot;
		slot = -1;
		for (i = 0; i < 16; i++)
			if (KEY_CODES[i] == code[7:0] && (i < 4 || !code[8]))  // Arrows take E0 too
				slot = i;
		return slot;
	endfunction

	//============================================================
	// Reference row byte
	//============================================================
	function automatic byte_t expected_row(input col_sel_t col);
		logic [3:0] dir1;
		logic [3:0] dir2;
		logic f1, f2, s1, s2, cn;
		byte_t row;
		// Right left down up, joystick word holds them low bit first
		dir1 = ~({keys[3], keys[2], keys[1], keys[0]}
			| {m_joy1[JOY_RIGHT], m_joy1[JOY_LEFT], m_joy1[JOY_DOWN], m_joy1[JOY_UP]});
		dir2 = ~({keys[8], keys[7], keys[6], keys[5]}
			| {m_joy2[JOY_RIGHT], m_joy2[JOY_LEFT], m_joy2[JOY_DOWN], m_joy2[JOY_UP]});
		f1 = keys[4] | m_joy1[4];
		f2 = keys[9] | m_joy2[4];
		s1 = keys[10] | keys[11] | m_joy1[6];
		s2 = keys[12] | keys[13] | m_joy1[7];
		cn = keys[14] | keys[15] | m_joy1[8];
		row = ROW_IDLE;
		if (col == 8'h08)
			row = m_dip_b;
		else if (m_game == GAME_SPACEZAP)
			case (col)
				8'h01: row = {2'b11, ~s2, ~s1, m_dip_a[1], 1'b1, ~cn, 1'b1};
				8'h02: row = {3'b111, ~f2, dir2};
				8'h04: row = {2'b11, m_dip_a[0], ~f1, dir1};
				default: ;
			endcase
		else if (m_game == GAME_GORF)
			case (col)
				8'h01: row = {m_dip_a[2], m_dip_a[0], ~s2, ~s1, 1'b1, m_dip_a[1], ~cn, 1'b1};
				8'h02: row = {3'b001, ~f2, dir2};
				8'h04: row = {m_speech, 2'b01, ~f1, dir1};
				default: ;
			endcase
		else if (m_game == GAME_ROBBY)
			case (col)
				8'h01: row = {1'b0, ~s2, ~s1, 1'b1, m_dip_a[1], 1'b1, ~cn, 1'b1};
				8'h02: row = {2'b11, ~f2, 1'b1, dir2};
				8'h04: row = {2'b11, ~f1, 1'b1, dir1};
				default: ;
			endcase
		return row;
	endfunction

	function automatic byte_t game_of(input int g);
		return (g == 0) ? GAME_SPACEZAP : (g == 1) ? GAME_GORF : GAME_ROBBY;
	endfunction

	// Mostly mapped codes, E0 bit set now and then
	function automatic logic [8:0] random_code();
		int idx;
		logic ext;
		idx = int'($urandom % 16);
		ext = ($urandom % 4) == 0;
		if ($urandom % 5 == 0)
			return {1'b0, 8'($urandom)};
		return {ext, KEY_CODES[idx[3:0]]};
	endfunction

	// One compare per cycle, levels taken from the model
	task automatic check_column(input col_sel_t col);
		@(posedge clk_sys);
		col_select  <= col;
		joy_p1      <= m_joy1;
		joy_p2      <= m_joy2;
		speech_busy <= m_speech;
		expected    <= expected_row(col);
		check_en    <= 1'b1;
		issued = issued + 1;
	endtask

	task automatic sweep_columns();
		int i;
		for (i = 0; i < 8; i++)
			check_column(col_sel_t'(1 << i));
		check_column(8'h00);
		check_column(8'h05);  // Two columns at once
		check_column(col_sel_t'($urandom));
	endtask

	// Strobe plus one idle edge, enough for the game flags
	task automatic loader_write(input load_index_t index, input load_addr_t addr,
		input byte_t data);
		@(posedge clk_sys);
		load_wr    <= 1'b1;
		load_index <= index;
		load_addr  <= addr;
		load_data  <= data;
		check_en   <= 1'b0;
		@(posedge clk_sys);
		load_wr <= 1'b0;
		if (index == INDEX_GAME)
			m_game = data;
		else if (index == INDEX_DIP && addr == load_addr_t'(DIP_FIRST))
			m_dip_a = data;
		else if (index == INDEX_DIP && addr == load_addr_t'(DIP_FIRST + 1))
			m_dip_b = data;
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		int slot;
		slot = key_slot(code);
		m_toggle = ~m_toggle;
		@(posedge clk_sys);
		ps2_key  <= {m_toggle, pressed, code};
		check_en <= 1'b0;  // Latched one edge later
		if (slot >= 0)
			keys[slot[3:0]] = pressed;
	endtask

	task automatic wait_for_checker();
		int t;
		t = 0;
		@(posedge clk_sys);
		check_en <= 1'b0;
		while (checks < issued && t < CHECK_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (checks < issued) begin
			$display("Timeout: checker finished %0d of %0d checks", checks, issued);
			timed_out = 1'b1;
		end
	endtask

	//============================================================
	// Stimulus
	//============================================================
	initial begin
		int g;
		int n;
		void'($urandom(79));
		reset       <= 1'b1;
		load_wr     <= 1'b0;
		load_index  <= '0;
		load_addr   <= '0;
		load_data   <= '0;
		ps2_key     <= '0;
		joy_p1      <= '0;
		joy_p2      <= '0;
		speech_busy <= 1'b0;
		col_select  <= '0;
		expected    <= '0;
		check_en    <= 1'b0;
		{m_game, m_dip_a, m_dip_b, m_joy1, m_joy2} = '0;
		keys      = '0;
		m_speech  = 1'b0;
		m_toggle  = 1'b0;
		issued    = 0;
		timed_out = 1'b0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		sweep_columns();  // Reset rows

		// Games with random DIP banks and stray DIP writes
		for (g = 0; g < 3; g++) begin
			loader_write(INDEX_GAME, '0, game_of(g));
			loader_write(INDEX_DIP, load_addr_t'(DIP_FIRST), byte_t'($urandom));
			loader_write(INDEX_DIP, load_addr_t'(DIP_FIRST + 1), byte_t'($urandom));
			loader_write(INDEX_DIP, load_addr_t'($urandom % 2), byte_t'($urandom));
			loader_write(INDEX_DIP, load_addr_t'(DIP_FIRST + 2), byte_t'($urandom));
			loader_write(8'd7, load_addr_t'(DIP_FIRST), byte_t'($urandom));
			sweep_columns();
		end

		// Each mapped key pressed and released alone, arrows again as E0
		for (n = 0; n < 40; n++) begin
			send_key({n >= 32, KEY_CODES[(n / 2) % 16]}, n % 2 == 0);
			check_column(8'h01);
			check_column(8'h02);
			check_column(8'h04);
		end

		// Keyboard events, game changes every 20
		for (n = 0; n < 60; n++) begin
			if (n % 20 == 0)
				loader_write(INDEX_GAME, '0, game_of(n / 20));
			send_key(random_code(), 1'($urandom % 2));
			check_column(8'h01);
			check_column(8'h02);
			check_column(8'h04);
		end

		// Joystick over held keys
		for (n = 0; n < 60; n++) begin
			if (n % 20 == 0)
				loader_write(INDEX_GAME, '0, game_of(n / 20));
			m_joy1 = joy_t'($urandom);
			m_joy2 = joy_t'($urandom);
			check_column(8'h01);
			check_column(8'h02);
			check_column(8'h04);
		end
		m_joy1 = '0;
		m_joy2 = '0;

		// Speech busy, seen only under Gorf
		for (g = 0; g < 3; g++) begin
			loader_write(INDEX_GAME, '0, game_of(g));
			for (n = 0; n < 8; n++) begin
				m_speech = ~m_speech;
				check_column(8'h04);
			end
		end

		// Game numbers outside the kept set
		loader_write(INDEX_GAME, '0, 8'd5);
		sweep_columns();
		loader_write(INDEX_GAME, '0, 8'hC4);
		sweep_columns();

		wait_for_checker();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/panel_pkg.sv
hdl/game_config.sv
hdl/key_decoder.sv
hdl/switch_matrix.sv
hdl/control_panel.sv
sim/panel_checker.sv
sim/tb_control_panel.sv
